// File: buster_assertions.sv
/* Handshake rules between FCS, DSACK and the Zorro strobes.
   Sampled on clk100 and ignored while arst_n is low. */
`include "zorro_defs.svh"

module buster_assertions (
    input logic              clk100,
    input logic              arst_n,
    input logic              as_n,
    input logic              fcs_n,
    input logic              dsack_oe,
    input zorro_pkg::dsack_t dsack_n,
    input zorro_pkg::eds_t   eds_n
);

    // An active size acknowledge only inside a Zorro cycle
    a_dsack_in_cycle: assert property (@(posedge clk100) disable iff (!arst_n)
        fcs_n |-> (dsack_n == 2'b11))
        else $error("DSACK active while FCS is high");

    a_eds_idle: assert property (@(posedge clk100) disable iff (!arst_n)
        fcs_n |-> (eds_n == `EDS_IDLE))
        else $error("Data strobes active while FCS is high");

    // FCS is held for as long as the CPU keeps AS low under DSACK
    a_fcs_held: assert property (@(posedge clk100) disable iff (!arst_n)
        (dsack_oe && !as_n) |-> !fcs_n)
        else $error("FCS released while DSACK is still held");

    a_dsack_after_fcs: assert property (@(posedge clk100) disable iff (!arst_n)
        $fell(dsack_oe) |-> fcs_n)
        else $error("DSACK enable dropped before FCS was released");

endmodule

bind buster_top buster_assertions u_buster_assertions (
    .clk100   (clk100),
    .arst_n   (arst_n),
    .as_n     (as_n),
    .fcs_n    (fcs_n),
    .dsack_oe (dsack_oe),
    .dsack_n  (dsack_n),
    .eds_n    (eds_n)
);

// File: buster_patterns.txt
# name space rw siz a cinh_n xrdy_low dtack_delay then expected eds_n dsack_n ciin_n
# All numbers hex, dtack_delay in CPU clocks for z3 and C7M clocks for z2, ff for never
z3_long_rd      z3    1 0 0 1 0 3  0 0 1
z3_byte1_wr     z3    0 1 1 1 0 2  b 0 1
z3_word2_rd_ci  z3    1 2 2 0 0 1  c 0 0
z3_tri1_wr      z3    0 3 1 1 0 4  8 0 1
z3_long_a3_rd   z3    1 0 3 1 0 2  e 0 1
z3_tri2_rd      z3    1 3 6 1 0 0  c 0 1
z3_timeout_rd   z3    1 0 0 1 0 ff 0 0 1
z2m_byte_rd     z2mem 1 1 0 1 0 ff 7 1 1
z2m_word_wr     z2mem 0 2 2 1 0 ff 3 1 1
z2io_odd_rd     z2io  1 1 3 1 0 ff b 1 0
z2io_long_wr    z2io  0 0 4 1 0 ff 3 1 0
z2m_xrdy_rd     z2mem 1 2 0 1 5 ff 3 1 1
other_rd        other 1 0 8 1 0 ff f 3 1
z3_after_other  z3    1 1 2 1 0 2  d 0 1
z2m_after_z3    z2mem 0 1 e 1 0 ff 7 1 1

// File: buster_top.sv
/* Level I bus controller without DMA, bursts or bus arbitration.
   Tristate pins are given as a level plus an output enable. */
module buster_top (
    input  logic                clk100,
    input  logic                arst_n,
    input  logic                cpuclk,
    input  logic                c7m,
    input  logic [3:0]          a,
    input  logic                rw,
    input  zorro_pkg::siz_t     siz,
    input  logic                as_n,
    input  logic                addrz3_n,
    input  logic                memz2_n,
    input  logic                ioz2_n,
    input  logic                cinh_n,
    input  logic                xrdy,
    input  logic                dtack_n_in,
    output zorro_pkg::aboe_t    aboe_n,
    output zorro_pkg::dboe_t    dboe_n,
    output logic                d2p_n,
    output logic                dblt,
    output zorro_pkg::dsack_t   dsack_n,
    output logic                dsack_oe,
    output logic                ciin_n,
    output logic                ciin_oe,
    output logic                read,
    output logic [3:1]          ea,
    output logic                fcs_n,
    output logic                ccs_n,
    output zorro_pkg::eds_t     eds_n,
    output logic                doe,
    output logic                dtack_oe
);
    import zorro_pkg::*;

    logic cpu_rise, cpu_fall, c7m_rise, c7m_fall, dtack_s1, dtack_s2;
    logic z3_req, z3_ack, z3_rel, z3_doe, z3_dsack_oe, z3_ciin_n, z3_ciin_oe;
    logic z2_req, z2_ack, z2_rel, z2_doe, z2_dsack_oe, z2_ciin_n, z2_ciin_oe;
    logic word_addr;
    eds_t   z3_pat, z2_pat, z3_eds_n, z2_eds_n;
    aboe_t  z3_aboe_n, z2_aboe_n;
    dboe_t  z3_dboe_n, z2_dboe_n;
    dsack_t z3_dsack_n, z2_dsack_n;

    assign d2p_n = ~rw;          // Buffers point at the CPU on reads
    assign read  = rw;
    assign ea    = {a[3:2], word_addr ? a[1] : 1'b1};

    clock_sync u_clock_sync (
        .clk100, .arst_n, .cpuclk, .c7m, .dtack_n_in,
        .cpu_rise, .cpu_fall, .c7m_rise, .c7m_fall, .dtack_s1, .dtack_s2
    );

    byte_lane_decode u_byte_lane_decode (
        .siz, .a_low(a[1:0]), .z3_eds(z3_pat), .z2_eds(z2_pat)
    );

    z3_cycle u_z3_cycle (
        .clk100, .arst_n, .req(z3_req), .cpu_rise, .cpu_fall, .as_n, .cinh_n,
        .dtack_s1, .eds_pat(z3_pat), .ack(z3_ack), .release_fcs(z3_rel),
        .doe(z3_doe), .dsack_oe(z3_dsack_oe), .ciin_n(z3_ciin_n),
        .ciin_oe(z3_ciin_oe), .aboe_n(z3_aboe_n), .dboe_n(z3_dboe_n),
        .eds_n(z3_eds_n), .dsack_n(z3_dsack_n)
    );

    z2_cycle u_z2_cycle (
        .clk100, .arst_n, .req(z2_req), .cpu_rise, .cpu_fall, .c7m_rise,
        .c7m_fall, .as_n, .rw, .ioz2_n, .xrdy, .cinh_n, .dtack_s2,
        .eds_pat(z2_pat), .ack(z2_ack), .release_fcs(z2_rel), .word_addr,
        .dblt, .ccs_n, .doe(z2_doe), .dtack_oe, .dsack_oe(z2_dsack_oe),
        .ciin_n(z2_ciin_n), .ciin_oe(z2_ciin_oe), .aboe_n(z2_aboe_n),
        .dboe_n(z2_dboe_n), .eds_n(z2_eds_n), .dsack_n(z2_dsack_n)
    );

    cycle_dispatch u_cycle_dispatch (
        .clk100, .arst_n, .cpu_rise, .cpu_fall, .as_n, .addrz3_n, .memz2_n, .ioz2_n,
        .z3_ack, .z3_release_fcs(z3_rel), .z3_doe, .z3_dsack_oe, .z3_ciin_n,
        .z3_ciin_oe, .z3_aboe_n, .z3_dboe_n, .z3_eds_n, .z3_dsack_n,
        .z2_ack, .z2_release_fcs(z2_rel), .z2_doe, .z2_dsack_oe, .z2_ciin_n,
        .z2_ciin_oe, .z2_aboe_n, .z2_dboe_n, .z2_eds_n, .z2_dsack_n,
        .z3_req, .z2_req, .fcs_n, .aboe_n, .dboe_n, .eds_n, .doe,
        .dsack_n, .dsack_oe, .ciin_n, .ciin_oe
    );

endmodule

// File: byte_lane_decode.sv
/* Lane 0 is eds[3]. Size 0 means a long word, and lanes past the
   last one are clipped, so misaligned accesses need further CPU cycles. */
module byte_lane_decode (
    input  zorro_pkg::siz_t siz,
    input  logic [1:0]      a_low,
    output zorro_pkg::eds_t z3_eds,
    output zorro_pkg::eds_t z2_eds
);

    logic [2:0] byte_count;

    // Zorro 3 takes every lane from the address up to the size
    always_comb begin
        byte_count = (siz == 2'd0) ? 3'd4 : {1'b0, siz};
        z3_eds = 4'b1111;
        for (int lane = 0; lane < 4; lane++) begin
            if (lane >= a_low && lane < a_low + byte_count) begin
                z3_eds[3 - lane] = 1'b0;
            end
        end
    end

    // Zorro 2 is a 16-bit bus on the upper lanes
    always_comb begin
        if (a_low[0]) begin
            z2_eds = 4'b1011;        // Odd byte
        end else if (siz == 2'd1) begin
            z2_eds = 4'b0111;        // Even byte
        end else begin
            z2_eds = 4'b0011;        // Word
        end
    end

endmodule

// File: clock_sync.sv
/* Edge pulses appear 2 to 3 clk100 cycles after the pin edge.
   cpuclk and c7m must stay at each level for at least 2 clk100 cycles. */
`include "zorro_defs.svh"

module clock_sync (
    input  logic clk100,
    input  logic arst_n,
    input  logic cpuclk,
    input  logic c7m,
    input  logic dtack_n_in,
    output logic cpu_rise,
    output logic cpu_fall,
    output logic c7m_rise,
    output logic c7m_fall,
    output logic dtack_s1,
    output logic dtack_s2
);

    logic [`SYNC_STAGES-1:0] sync_sh [2];  // 0 is cpuclk, 1 is c7m
    logic [1:0]              phase [2];    // {older, newer} sample

    always_ff @(posedge clk100 or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 2; i++) begin
                sync_sh[i] <= '0;
                phase[i]   <= 2'b00;
            end
            dtack_s1 <= 1'b1;
            dtack_s2 <= 1'b1;
        end else begin
            sync_sh[0] <= {sync_sh[0][`SYNC_STAGES-2:0], cpuclk};
            sync_sh[1] <= {sync_sh[1][`SYNC_STAGES-2:0], c7m};
            for (int i = 0; i < 2; i++) begin
                phase[i] <= sync_sh[i][`SYNC_STAGES-1 -: 2];
            end
            dtack_s1 <= dtack_n_in;  // Still active low
            dtack_s2 <= dtack_s1;
        end
    end

    // 01 is a low-to-high step, 10 the opposite
    assign cpu_rise = (phase[0] == 2'b01);
    assign cpu_fall = (phase[0] == 2'b10);
    assign c7m_rise = (phase[1] == 2'b01);
    assign c7m_fall = (phase[1] == 2'b10);

endmodule

// File: cycle_dispatch.sv
/* Classifies an access on the second CPU clock with AS low.
   Accesses outside both Zorro spaces get no acknowledge from here. */
`include "zorro_defs.svh"

module cycle_dispatch (
    input  logic                clk100,
    input  logic                arst_n,
    input  logic                cpu_rise,
    input  logic                cpu_fall,
    input  logic                as_n,
    input  logic                addrz3_n,
    input  logic                memz2_n,
    input  logic                ioz2_n,
    input  logic                z3_ack,
    input  logic                z3_release_fcs,
    input  logic                z3_doe,
    input  logic                z3_dsack_oe,
    input  logic                z3_ciin_n,
    input  logic                z3_ciin_oe,
    input  zorro_pkg::aboe_t    z3_aboe_n,
    input  zorro_pkg::dboe_t    z3_dboe_n,
    input  zorro_pkg::eds_t     z3_eds_n,
    input  zorro_pkg::dsack_t   z3_dsack_n,
    input  logic                z2_ack,
    input  logic                z2_release_fcs,
    input  logic                z2_doe,
    input  logic                z2_dsack_oe,
    input  logic                z2_ciin_n,
    input  logic                z2_ciin_oe,
    input  zorro_pkg::aboe_t    z2_aboe_n,
    input  zorro_pkg::dboe_t    z2_dboe_n,
    input  zorro_pkg::eds_t     z2_eds_n,
    input  zorro_pkg::dsack_t   z2_dsack_n,
    output logic                z3_req,
    output logic                z2_req,
    output logic                fcs_n,
    output zorro_pkg::aboe_t    aboe_n,
    output zorro_pkg::dboe_t    dboe_n,
    output zorro_pkg::eds_t     eds_n,
    output logic                doe,
    output zorro_pkg::dsack_t   dsack_n,
    output logic                dsack_oe,
    output logic                ciin_n,
    output logic                ciin_oe
);
    import zorro_pkg::*;

    access_t    access;
    logic [1:0] as_hist;      // AS asserted on the last two rises
    aboe_t      idle_aboe_n;  // Buffers open from the first clock after reset

    always_ff @(posedge clk100 or negedge arst_n) begin
        if (!arst_n) begin
            access      <= ACC_IDLE;
            as_hist     <= 2'b00;
            fcs_n       <= 1'b1;
            z3_req      <= 1'b0;
            z2_req      <= 1'b0;
            idle_aboe_n <= `ABOE_IDLE;
        end else begin
            idle_aboe_n <= 3'b000;
            if (cpu_rise) as_hist <= {as_hist[0], ~as_n};
            if (z3_release_fcs || z2_release_fcs) fcs_n <= 1'b1;

            case (access)
                ACC_IDLE: begin
                    if (cpu_fall && as_hist == 2'b11 && !z3_ack && !z2_ack) begin
                        if (!addrz3_n) begin
                            fcs_n  <= 1'b0;
                            z3_req <= 1'b1;
                            access <= ACC_Z3;
                        end else if (!memz2_n || !ioz2_n) begin
                            fcs_n  <= 1'b0;
                            z2_req <= 1'b1;
                            access <= ACC_Z2;
                        end else begin
                            access <= ACC_OTHER;
                        end
                    end
                end
                ACC_OTHER: if (cpu_rise && as_n) access <= ACC_IDLE;
                ACC_Z3: if (z3_ack) begin
                    z3_req <= 1'b0;
                    access <= ACC_IDLE;
                end
                ACC_Z2: if (z2_ack) begin
                    z2_req <= 1'b0;
                    access <= ACC_IDLE;
                end
            endcase
        end
    end

    always_comb begin
        case (access)
            ACC_Z3: begin
                {aboe_n, dboe_n, eds_n, doe} = {z3_aboe_n, z3_dboe_n, z3_eds_n, z3_doe};
                {dsack_n, dsack_oe} = {z3_dsack_n, z3_dsack_oe};
                {ciin_n, ciin_oe}   = {z3_ciin_n, z3_ciin_oe};
            end
            ACC_Z2: begin
                {aboe_n, dboe_n, eds_n, doe} = {z2_aboe_n, z2_dboe_n, z2_eds_n, z2_doe};
                {dsack_n, dsack_oe} = {z2_dsack_n, z2_dsack_oe};
                {ciin_n, ciin_oe}   = {z2_ciin_n, z2_ciin_oe};
            end
            default: begin
                {aboe_n, dboe_n, eds_n, doe} = {idle_aboe_n, 2'b11, `EDS_IDLE, 1'b0};
                {dsack_n, dsack_oe} = {2'b11, 1'b0};
                {ciin_n, ciin_oe}   = {1'b1, 1'b0};
            end
        endcase
    end

endmodule

// File: filelist.f
+incdir+.
zorro_pkg.sv
clock_sync.sv
byte_lane_decode.sv
z3_cycle.sv
z2_cycle.sv
cycle_dispatch.sv
buster_top.sv
buster_assertions.sv
tb_buster.sv

// File: run.sh
#!/bin/sh
# Build and run the testbench with Verilator from the project root
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module tb_buster -f filelist.f
./obj_dir/Vtb_buster > sim.log 2>&1 || true
cat sim.log
if grep -q "Testbench failed" sim.log; then
    exit 1
fi
grep -q "Testbench passed" sim.log
exit 0

// File: tb_buster.sv
/* Replays buster_patterns.txt, one CPU access per line, run from the project root.
   cpuclk is clk100 / 4 and c7m is clk100 / 14, both taken from clk100 counts. */
`include "zorro_defs.svh"

module tb_buster;
    import zorro_pkg::*;

    localparam int CPU_PERIOD = 400;   // Four clk100 periods
    localparam int MAX_PAT    = 64;

    logic       clk100, arst_n, cpuclk, c7m;
    logic [3:0] a;
    logic       rw, as_n, addrz3_n, memz2_n, ioz2_n, cinh_n, xrdy, dtack_n_in;
    siz_t       siz;
    aboe_t      aboe_n;
    dboe_t      dboe_n;
    dsack_t     dsack_n;
    eds_t       eds_n;
    logic       d2p_n, dblt, dsack_oe, ciin_n, ciin_oe, read;
    logic       fcs_n, ccs_n, doe, dtack_oe;
    logic [3:1] ea;

    // Pattern table, one entry per file line
    string       p_name [MAX_PAT];
    string       p_space [MAX_PAT];
    logic [31:0] p_rw [MAX_PAT], p_siz [MAX_PAT], p_a [MAX_PAT];
    logic [31:0] p_cinh [MAX_PAT], p_xrdy [MAX_PAT], p_delay [MAX_PAT];
    logic [31:0] p_eds [MAX_PAT], p_dsack [MAX_PAT], p_ciin [MAX_PAT];

    int          n_pat;
    bit          loaded;
    int          tick;
    logic        slave_dtack;      // Slave side of the wired DTACK line
    logic [31:0] slave_delay;
    logic [31:0] xrdy_hold;        // C7M clocks the slave keeps XRDY low
    time         xrdy_up_time;

    buster_top u_buster_top (.*);

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual) begin
            $display("CHECK FAILED %s expected %0h actual %0h", name, expected, actual);
            $display("Testbench failed");
            $fatal(1, "mismatch in %s", name);
        end
    endtask

    initial begin
        clk100 = 1'b0;
        forever #50 clk100 = ~clk100;
    end

    // Derived clocks and the DTACK line, 10 units after each rising edge
    always @(posedge clk100) begin
        #10;
        tick = tick + 1;
        cpuclk = (tick % 4) < 2;
        c7m = (tick % 14) < 7;
        dtack_n_in = !(dtack_oe || slave_dtack);
    end

    // Slave DTACK, counted in CPU clocks for Zorro 3 and C7M clocks for Zorro 2
    always @(negedge fcs_n) begin
        if (slave_delay != 32'hff) begin
            repeat (slave_delay) begin
                if (!addrz3_n) @(posedge cpuclk);
                else @(posedge c7m);
            end
            @(negedge clk100);
            slave_dtack = 1'b1;
            @(posedge fcs_n);
            @(negedge clk100);
            slave_dtack = 1'b0;
        end
    end

    always @(negedge ccs_n) begin
        if (xrdy_hold != 0) begin
            repeat (xrdy_hold) @(posedge c7m);
            @(posedge clk100);
            #10;
            xrdy = 1'b1;
            xrdy_up_time = $time;
        end
    end

    initial begin
        wait (loaded);
        #((n_pat * 80 + 20) * CPU_PERIOD);
        $display("Watchdog expired before all accesses completed");
        $display("Testbench failed");
        $fatal(1, "timeout");
    end

    task automatic load_patterns;
        int    fd;
        int    fields;
        string line;
        fd = $fopen("buster_patterns.txt", "r");
        if (fd == 0) begin
            $display("Could not open buster_patterns.txt");
            $display("Testbench failed");
            $fatal(1, "no pattern file");
        end else begin
            while (!$feof(fd) && n_pat < MAX_PAT) begin
                fields = $fgets(line, fd);
                if (fields > 0 && line[0] != "#") begin   // Skip column notes
                    fields = $sscanf(line, "%s %s %h %h %h %h %h %h %h %h %h",
                        p_name[n_pat], p_space[n_pat], p_rw[n_pat], p_siz[n_pat],
                        p_a[n_pat], p_cinh[n_pat], p_xrdy[n_pat], p_delay[n_pat],
                        p_eds[n_pat], p_dsack[n_pat], p_ciin[n_pat]);
                    if (fields == 11) n_pat++;
                end
            end
            $fclose(fd);
        end
    endtask

    // CPU model for one access, then the slave's view of the result
    task automatic run_access(input int i);
        string nm;
        int    rises;
        logic  cpu_prev;
        logic  stray;
        time   ack_time;
        nm = p_name[i];
        ack_time = 0;
        @(posedge cpuclk);
        a           = p_a[i][3:0];
        rw          = p_rw[i][0];
        siz         = p_siz[i][1:0];
        cinh_n      = p_cinh[i][0];
        addrz3_n    = (p_space[i] != "z3");
        memz2_n     = (p_space[i] != "z2mem");
        ioz2_n      = (p_space[i] != "z2io");
        xrdy        = (p_xrdy[i] == 0);
        xrdy_hold   = p_xrdy[i];
        slave_delay = p_delay[i];
        as_n        = 1'b0;

        if (p_space[i] == "other") begin
            stray = 1'b0;
            repeat (20 * 4) begin
                @(negedge clk100);
                if (dsack_oe || !fcs_n) stray = 1'b1;
            end
            check({nm, "_quiet"}, 0, stray);
        end else begin
            rises = 0;
            cpu_prev = cpuclk;
            do begin
                @(negedge clk100);
                if (!fcs_n && cpuclk && !cpu_prev) rises++;
                cpu_prev = cpuclk;
            end while (!dsack_oe);
            ack_time = $time;
        end

        check({nm, "_eds"}, p_eds[i], eds_n);
        check({nm, "_dsack"}, p_dsack[i], dsack_n);
        check({nm, "_ciin"}, p_ciin[i], ciin_n);
        check({nm, "_read"}, rw, read);
        check({nm, "_d2p"}, !rw, d2p_n);           // Low while data flows to the CPU
        check({nm, "_ea_hi"}, a[3:2], ea[3:2]);
        if (p_space[i] == "z2mem" || p_space[i] == "z2io") begin
            check({nm, "_ccs"}, 0, ccs_n);
            check({nm, "_ea1"}, a[1], ea[1]);
            check({nm, "_dblt"}, rw, dblt);
        end
        // DTACK ends a Zorro 3 cycle early, only a silent slave reaches the timeout
        if (p_space[i] == "z3")
            check({nm, "_timeout"}, p_delay[i] == 32'hff, rises >= `ZORRO_TIMEOUT);
        if (p_xrdy[i] != 0)
            check({nm, "_xrdy"}, 1, xrdy && ack_time > xrdy_up_time);

        // Back-pressure, DSACK must stay while AS is low
        if (p_space[i] != "other") begin
            repeat (2) @(posedge cpuclk);
            check({nm, "_held"}, 1, dsack_oe);
            check({nm, "_held_dsack"}, p_dsack[i], dsack_n);
        end else begin
            @(posedge cpuclk);
        end
        as_n = 1'b1;
        do @(negedge clk100); while (dsack_oe);
        check({nm, "_fcs_idle"}, 1, fcs_n);
        check({nm, "_ea1_idle"}, 1, ea[1]);
        check({nm, "_dboe_idle"}, 2'b11, dboe_n);
        repeat (4) @(posedge cpuclk);   // Let the sequencer finish its ack
    endtask

    initial begin
        arst_n      = 1'b0;
        cpuclk      = 1'b0;
        c7m         = 1'b0;
        a           = 4'h0;
        rw          = 1'b1;
        siz         = 2'd0;
        as_n        = 1'b1;
        addrz3_n    = 1'b1;
        memz2_n     = 1'b1;
        ioz2_n      = 1'b1;
        cinh_n      = 1'b1;
        xrdy        = 1'b1;
        dtack_n_in  = 1'b1;
        slave_dtack = 1'b0;
        slave_delay = 32'hff;
        xrdy_hold   = 0;
        xrdy_up_time = 0;
        tick        = 0;
        n_pat       = 0;
        load_patterns();
        check("pattern_count", 1, n_pat > 0);
        loaded = 1'b1;

        repeat (5) @(posedge clk100);
        #10;
        arst_n = 1'b1;
        repeat (3) @(negedge clk100);
        check("reset_dsack_oe", 0, dsack_oe);
        check("reset_ciin_oe", 0, ciin_oe);
        check("reset_doe", 0, doe);
        check("reset_dtack_oe", 0, dtack_oe);
        check("reset_dblt", 0, dblt);
        check("reset_fcs", 1, fcs_n);
        check("reset_ccs", 1, ccs_n);
        check("reset_eds", 4'hf, eds_n);
        check("reset_dboe", 2'b11, dboe_n);
        check("reset_aboe", 0, aboe_n);

        for (int i = 0; i < n_pat; i++) begin
            run_access(i);
        end
        $display("Testbench passed");
        $finish;
    end

endmodule

// File: z2_cycle.sv
/* One Zorro 2 cycle per req, no DMA. Strobes and CCS are held until
   the CPU negates AS, and the slave is never answered with BERR. */
`include "zorro_defs.svh"

module z2_cycle (
    input  logic                clk100,
    input  logic                arst_n,
    input  logic                req,
    input  logic                cpu_rise,
    input  logic                cpu_fall,
    input  logic                c7m_rise,
    input  logic                c7m_fall,
    input  logic                as_n,
    input  logic                rw,
    input  logic                ioz2_n,
    input  logic                xrdy,
    input  logic                cinh_n,
    input  logic                dtack_s2,
    input  zorro_pkg::eds_t     eds_pat,
    output logic                ack,
    output logic                release_fcs,
    output logic                word_addr,
    output logic                dblt,
    output logic                ccs_n,
    output logic                doe,
    output logic                dtack_oe,
    output logic                dsack_oe,
    output logic                ciin_n,
    output logic                ciin_oe,
    output zorro_pkg::aboe_t    aboe_n,
    output zorro_pkg::dboe_t    dboe_n,
    output zorro_pkg::eds_t     eds_n,
    output zorro_pkg::dsack_t   dsack_n
);
    import zorro_pkg::*;

    cyc_state_t state;
    c7m_state_t c7;

    assign release_fcs = (state == CYC_HOLD) && cpu_rise && as_n;

    always_ff @(posedge clk100 or negedge arst_n) begin
        if (!arst_n) begin
            state     <= CYC_IDLE;
            c7        <= C7_IDLE;
            ack       <= 1'b0;
            word_addr <= 1'b0;
            dblt      <= 1'b0;
            ccs_n     <= 1'b1;
            doe       <= 1'b0;
            dtack_oe  <= 1'b0;
            dsack_oe  <= 1'b0;
            ciin_n    <= 1'b1;
            ciin_oe   <= 1'b0;
            aboe_n    <= `ABOE_IDLE;
            dboe_n    <= 2'b11;
            eds_n     <= `EDS_IDLE;
            dsack_n   <= 2'b11;
        end else begin
            case (state)
                CYC_IDLE: begin
                    if (ack) begin
                        if (!req) ack <= 1'b0;
                    end else if (req && cpu_rise) begin
                        word_addr <= 1'b1;
                        aboe_n    <= 3'b100;
                        dblt      <= rw;
                        ciin_n    <= ioz2_n;     // I/O space is never cached
                        ciin_oe   <= ~ioz2_n;
                        state     <= CYC_ADDR;
                    end
                end
                CYC_ADDR:   if (cpu_fall) state <= CYC_STROBE;  // Address settled
                CYC_STROBE: if (c7 == C7_DONE && c7m_fall) state <= CYC_WAIT;
                CYC_WAIT: if (cpu_rise) begin
                    dsack_n  <= 2'b01;           // Word port
                    dsack_oe <= 1'b1;
                    state    <= CYC_HOLD;
                end
                CYC_HOLD: if (release_fcs) begin
                    aboe_n    <= 3'b110;
                    dboe_n    <= 2'b11;
                    dblt      <= 1'b0;
                    word_addr <= 1'b0;
                    ccs_n     <= 1'b1;
                    eds_n     <= `EDS_IDLE;
                    doe       <= 1'b0;
                    dsack_n   <= 2'b11;
                    ciin_n    <= 1'b1;
                    state     <= CYC_RELEASE;
                end
                CYC_RELEASE: if (cpu_fall) begin
                    dsack_oe <= 1'b0;
                    ciin_oe  <= 1'b0;
                    state    <= CYC_END;
                end
                CYC_END: if (cpu_fall) begin
                    aboe_n <= 3'b000;
                    ack    <= 1'b1;
                    state  <= CYC_IDLE;
                end
                default: state <= CYC_IDLE;
            endcase

            // Strobe machine
            case (c7)
                C7_IDLE:  if (state == CYC_STROBE) c7 <= C7_CCS;
                C7_CCS: if (c7m_rise) begin
                    ccs_n <= 1'b0;
                    if (rw) eds_n <= eds_pat;    // Reads strobe at once
                    else    dboe_n <= 2'b01;
                    c7 <= C7_SETUP;
                end
                C7_SETUP: if (c7m_fall) c7 <= C7_STROBE;
                C7_STROBE: if (c7m_rise) begin
                    if (rw) dboe_n <= 2'b01;
                    else    eds_n  <= eds_pat;   // Writes one period later
                    doe <= 1'b1;
                    if (xrdy && cinh_n) dtack_oe <= 1'b1;
                    c7 <= C7_WAIT;
                end
                C7_WAIT:  if (c7m_fall) c7 <= dtack_s2 ? C7_STROBE : C7_LATCH;
                C7_LATCH: if (c7m_rise) c7 <= C7_DONE;
                C7_DONE: if (c7m_fall) begin
                    dtack_oe <= 1'b0;
                    c7       <= C7_END;
                end
                C7_END:   if (c7m_rise) c7 <= C7_IDLE;
            endcase
        end
    end

endmodule

// File: z3_cycle.sv
/* One Zorro 3 full cycle per req. DSACK is forced after the timeout
   when no slave answers, so a missing card reads garbage. */
`include "zorro_defs.svh"

module z3_cycle (
    input  logic                clk100,
    input  logic                arst_n,
    input  logic                req,
    input  logic                cpu_rise,
    input  logic                cpu_fall,
    input  logic                as_n,
    input  logic                cinh_n,
    input  logic                dtack_s1,
    input  zorro_pkg::eds_t     eds_pat,
    output logic                ack,
    output logic                release_fcs,
    output logic                doe,
    output logic                dsack_oe,
    output logic                ciin_n,
    output logic                ciin_oe,
    output zorro_pkg::aboe_t    aboe_n,
    output zorro_pkg::dboe_t    dboe_n,
    output zorro_pkg::eds_t     eds_n,
    output zorro_pkg::dsack_t   dsack_n
);
    import zorro_pkg::*;

    localparam int TW = $clog2(`ZORRO_TIMEOUT + 1);

    cyc_state_t    state;
    logic [TW-1:0] timer;

    assign release_fcs = (state == CYC_HOLD) && cpu_rise && as_n;

    always_ff @(posedge clk100 or negedge arst_n) begin
        if (!arst_n) begin
            state    <= CYC_IDLE;
            timer    <= '0;
            ack      <= 1'b0;
            doe      <= 1'b0;
            dsack_oe <= 1'b0;
            ciin_n   <= 1'b1;
            ciin_oe  <= 1'b0;
            aboe_n   <= `ABOE_IDLE;
            dboe_n   <= 2'b11;
            eds_n    <= `EDS_IDLE;
            dsack_n  <= 2'b11;
        end else begin
            case (state)
                CYC_IDLE: begin
                    if (ack) begin
                        if (!req) ack <= 1'b0;
                    end else if (req && cpu_rise) begin
                        aboe_n <= 3'b110;        // Close upper address latch
                        state  <= CYC_ADDR;
                    end
                end
                CYC_ADDR: if (cpu_fall) begin
                    doe    <= 1'b1;
                    dboe_n <= 2'b00;
                    state  <= CYC_STROBE;
                end
                CYC_STROBE: if (cpu_rise) begin
                    eds_n   <= eds_pat;
                    ciin_n  <= cinh_n;
                    ciin_oe <= 1'b1;
                    timer   <= TW'(`ZORRO_TIMEOUT);
                    state   <= CYC_WAIT;
                end
                CYC_WAIT: if (cpu_rise) begin
                    if (!dtack_s1 || timer == '0) begin
                        dsack_n  <= 2'b00;       // Long-word port
                        dsack_oe <= 1'b1;
                        state    <= CYC_HOLD;
                    end else begin
                        timer <= timer - 1'b1;
                    end
                end
                CYC_HOLD: if (release_fcs) begin
                    eds_n   <= `EDS_IDLE;
                    dboe_n  <= 2'b11;
                    dsack_n <= 2'b11;
                    ciin_n  <= 1'b1;
                    state   <= CYC_RELEASE;
                end
                CYC_RELEASE: begin
                    doe <= 1'b0;                 // One clk100 after FCS
                    if (cpu_fall) begin
                        dsack_oe <= 1'b0;
                        ciin_oe  <= 1'b0;
                        state    <= CYC_END;
                    end
                end
                CYC_END: if (cpu_fall) begin
                    aboe_n <= 3'b000;
                    ack    <= 1'b1;
                    state  <= CYC_IDLE;
                end
                default: state <= CYC_IDLE;
            endcase
        end
    end

endmodule

// File: zorro_defs.svh
/* Shared constants of the local-bus-to-Zorro controller.
   Timeout counts CPU clock rises, strobes and enables are active low. */
`ifndef ZORRO_DEFS_SVH
`define ZORRO_DEFS_SVH

// Zorro 3 DTACK wait before DSACK is forced
`define ZORRO_TIMEOUT 40

// Flops in front of the clock edge detectors
`define SYNC_STAGES 2

// Idle levels
`define EDS_IDLE 4'b1111
`define ABOE_IDLE 3'b111

`endif

// File: zorro_pkg.sv
/* Types shared by the Zorro cycle controller and its testbench */
package zorro_pkg;

    typedef logic [3:0] eds_t;    // Zorro data strobes, active low
    typedef logic [1:0] siz_t;    // 68030 transfer size, 0 means four bytes
    typedef logic [2:0] aboe_t;   // Address buffer enables
    typedef logic [1:0] dboe_t;   // Data buffer enables
    typedef logic [1:0] dsack_t;  // CPU size acknowledge

    typedef enum logic [1:0] {
        ACC_IDLE,
        ACC_OTHER,
        ACC_Z3,
        ACC_Z2
    } access_t;

    // CPU-side sequence, same steps for both bus types
    typedef enum logic [2:0] {
        CYC_IDLE,
        CYC_ADDR,
        CYC_STROBE,
        CYC_WAIT,
        CYC_HOLD,
        CYC_RELEASE,
        CYC_END
    } cyc_state_t;

    // Zorro 2 strobe machine, paced by C7M
    typedef enum logic [2:0] {
        C7_IDLE,
        C7_CCS,
        C7_SETUP,
        C7_STROBE,
        C7_WAIT,
        C7_LATCH,
        C7_DONE,
        C7_END
    } c7m_state_t;

endpackage
